//--- vlog.f
rtl/mem_sys_pkg.sv
rtl/ifu_master.sv
rtl/lsu_master.sv
rtl/axi_arbiter.sv
rtl/axi_sram.sv
rtl/mem_sys.sv
dv/mem_sys_checker.sv
dv/tb_mem_sys.sv

//--- Bender.yml
package:
  name: mem_sys

sources:
  - files:
      - rtl/mem_sys_pkg.sv
      - rtl/ifu_master.sv
      - rtl/lsu_master.sv
      - rtl/axi_arbiter.sv
      - rtl/axi_sram.sv
      - rtl/mem_sys.sv
  - target: test
    files:
      - dv/mem_sys_checker.sv
      - dv/tb_mem_sys.sv

//--- dv/tb_mem_sys.sv
`timescale 1ns/1ps

module tb_mem_sys import mem_sys_pkg::*; ();

    localparam int    MEM_WORDS    = 256;
    localparam int    RESP_LATENCY = 2;
    localparam int    CLK_NS       = 100;
    localparam int    NUM_RAND     = 40;
    localparam int    NUM_OPS      = MEM_WORDS + 2 + 3 + 2 + 12 + 4 + 2 * NUM_RAND;
    localparam int    WATCHDOG_NS  = NUM_OPS * (RESP_LATENCY + 10) * 2 * CLK_NS;
    localparam addr_t ADDR_END     = addr_t'(MEM_WORDS * 4);

    logic    clk;
    logic    rst;
    logic    fetch_start;
    addr_t   fetch_addr;
    logic    fetch_busy;
    logic    fetch_done;
    data_t   fetch_inst;
    logic    fetch_err;
    logic    ls_start;
    lsu_op_e ls_op;
    addr_t   ls_addr;
    data_t   ls_wdata;
    strb_t   ls_wstrb;
    logic    ls_busy;
    logic    ls_done;
    data_t   ls_rdata;
    logic    ls_err;

    data_t model [MEM_WORDS]; // expected memory contents
    string cur_test;
    int    err_count;
    int    errs_at_start;
    int    tests_run;
    int    tests_failed;

    mem_sys #(
        .MEM_WORDS    (MEM_WORDS),
        .RESP_LATENCY (RESP_LATENCY)
    ) i_mem_sys (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done),
        .fetch_inst  (fetch_inst),
        .fetch_err   (fetch_err),
        .ls_start    (ls_start),
        .ls_op       (ls_op),
        .ls_addr     (ls_addr),
        .ls_wdata    (ls_wdata),
        .ls_wstrb    (ls_wstrb),
        .ls_busy     (ls_busy),
        .ls_done     (ls_done),
        .ls_rdata    (ls_rdata),
        .ls_err      (ls_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    function automatic data_t fill_word(int idx);
        data_t a;
        a = data_t'(idx * 4);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // spreads every address bit
    endfunction

    task automatic compare_data(string what, data_t exp, data_t act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_err(string what, logic exp, logic act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s (%s): expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_busy(string what, logic exp, logic act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s (%s): expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, err_count - errs_at_start);
        end
    endtask

    task automatic do_fetch(addr_t addr);
        data_t exp;
        logic  oor;
        oor = addr >= ADDR_END;
        exp = oor ? '0 : model[int'(addr >> 2)];
        @(posedge clk);
        fetch_start <= 1'b1;
        fetch_addr  <= addr;
        @(posedge clk);
        fetch_start <= 1'b0;
        do begin
            @(negedge clk);
            compare_busy("fetch_busy", 1'b1, fetch_busy);
        end while (fetch_done !== 1'b1);
        compare_data("fetch_inst", exp, fetch_inst);
        compare_err("fetch_err", oor, fetch_err);
        @(negedge clk);
        compare_busy("fetch_busy after done", 1'b0, fetch_busy);
    endtask

    task automatic do_ls(lsu_op_e op, addr_t addr, data_t wdata, strb_t wstrb);
        data_t exp;
        logic  oor;
        int    idx;
        oor = addr >= ADDR_END;
        idx = int'(addr >> 2);
        exp = (op == OP_LOAD && !oor) ? model[idx] : '0; // stores always return zero
        if (op == OP_STORE && !oor) model[idx] = merge_bytes(model[idx], wdata, wstrb);
        @(posedge clk);
        ls_start <= 1'b1;
        ls_op    <= op;
        ls_addr  <= addr;
        ls_wdata <= wdata;
        ls_wstrb <= wstrb;
        @(posedge clk);
        ls_start <= 1'b0;
        do begin
            @(negedge clk);
            compare_busy("ls_busy", 1'b1, ls_busy);
        end while (ls_done !== 1'b1);
        compare_data("ls_rdata", exp, ls_rdata);
        compare_err("ls_err", oor, ls_err);
        @(negedge clk);
        compare_busy("ls_busy after done", 1'b0, ls_busy);
    endtask

    // every word gets a known value so later reads never see X
    task automatic fill_memory();
        begin_test("fill_memory");
        for (int i = 0; i < MEM_WORDS; i++) begin
            do_ls(OP_STORE, addr_t'(i * 4), fill_word(i), 4'hf);
        end
        finish_test();
    endtask

    task automatic store_then_load();
        begin_test("store_then_load");
        do_ls(OP_STORE, 32'h40, 32'hdead_beef, 4'hf);
        do_ls(OP_LOAD, 32'h40, '0, '0);
        finish_test();
    endtask

    task automatic partial_store();
        begin_test("partial_store");
        do_ls(OP_STORE, 32'h80, 32'h1122_3344, 4'hf);
        do_ls(OP_STORE, 32'h80, 32'haabb_ccdd, 4'b0101);
        do_ls(OP_LOAD, 32'h80, '0, '0);
        compare_data("merged word", 32'h11bb_33dd, ls_rdata);
        finish_test();
    endtask

    task automatic fetch_after_store();
        begin_test("fetch_after_store");
        do_ls(OP_STORE, 32'hc0, 32'h0000_0013, 4'hf);
        do_fetch(32'hc0);
        finish_test();
    endtask

    task automatic simultaneous_start();
        begin_test("simultaneous_start");
        for (int p = 0; p < 4; p++) begin
            fork
                do_fetch(addr_t'(32'h104 + p * 8));
                do_ls(OP_STORE, addr_t'(32'h100 + p * 8), 32'hcafe_0000 + p, 4'hf);
            join
        end
        for (int p = 0; p < 4; p++) begin
            do_ls(OP_LOAD, addr_t'(32'h100 + p * 8), '0, '0);
        end
        finish_test();
    endtask

    // the store aliases onto word 1 if the range check were missing
    task automatic out_of_range();
        begin_test("out_of_range");
        do_ls(OP_LOAD, ADDR_END, '0, '0);
        do_ls(OP_STORE, ADDR_END + 4, 32'hffff_ffff, 4'hf);
        do_fetch(ADDR_END + 32'h100);
        do_ls(OP_LOAD, 32'h4, '0, '0);
        finish_test();
    endtask

    task automatic random_stream();
        int      kind;
        int      li;
        int      fi;
        int      delay;
        lsu_op_e op;
        data_t   wdata;
        strb_t   strb;
        begin_test("random_stream");
        for (int i = 0; i < NUM_RAND; i++) begin
            kind  = $urandom_range(0, 2);
            li    = $urandom_range(0, MEM_WORDS - 1);
            fi    = $urandom_range(0, MEM_WORDS - 1);
            op    = lsu_op_e'($urandom_range(0, 1));
            delay = $urandom_range(0, 3);
            wdata = $urandom;
            strb  = strb_t'($urandom_range(1, 15));
            if (fi == li) fi = (fi + 1) % MEM_WORDS; // ports never touch the same word
            case (kind)
                0: do_fetch(addr_t'(fi * 4));
                1: do_ls(op, addr_t'(li * 4), wdata, strb);
                default: begin
                    fork
                        begin
                            repeat (delay) @(posedge clk);
                            do_fetch(addr_t'(fi * 4));
                        end
                        do_ls(op, addr_t'(li * 4), wdata, strb);
                    join
                end
            endcase
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h64da));
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        fetch_start  = 1'b0;
        fetch_addr   = '0;
        ls_start     = 1'b0;
        ls_op        = OP_LOAD;
        ls_addr      = '0;
        ls_wdata     = '0;
        ls_wstrb     = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fill_memory();
        store_then_load();
        partial_store();
        fetch_after_store();
        simultaneous_start();
        out_of_range();
        random_stream();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dv/mem_sys_checker.sv
`timescale 1ns/1ps

module arbiter_checker import mem_sys_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       sel,
    input arb_state_e m0_state,
    input arb_state_e m1_state,
    input axi_rsp_t   m0_rsp,
    input axi_rsp_t   m1_rsp,
    input axi_req_t   s_req,
    input axi_rsp_t   s_rsp
);

    function automatic logic quiet(axi_rsp_t p);
        return !(p.r_valid || p.b_valid || p.ar_ready || p.aw_ready || p.w_ready);
    endfunction

    // sel low means fetch owns the slave
    m0_quiet: assert property (@(posedge clk) disable iff (rst) sel |-> quiet(m0_rsp))
        else $error("fetch master saw a handshake while load/store owned the slave");

    m1_quiet: assert property (@(posedge clk) disable iff (rst) !sel |-> quiet(m1_rsp))
        else $error("load/store master saw a handshake while fetch owned the slave");

    sel_hold: assert property (@(posedge clk) disable iff (rst)
        (m0_state == ARB_BUSY || m1_state == ARB_BUSY) |=> $stable(sel))
        else $error("owner select changed while a master was busy");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        s_req.ar_valid && !s_rsp.ar_ready |=> s_req.ar_valid && $stable(s_req.ar_addr))
        else $error("read address dropped or changed before ar_ready");

endmodule

bind axi_arbiter arbiter_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .sel      (sel),
    .m0_state (m0_state),
    .m1_state (m1_state),
    .m0_rsp   (m0_rsp),
    .m1_rsp   (m1_rsp),
    .s_req    (s_req),
    .s_rsp    (s_rsp)
);

//--- rtl/mem_sys.sv
`timescale 1ns/1ps

module mem_sys import mem_sys_pkg::*; #(
    parameter int MEM_WORDS    = 256,
    parameter int RESP_LATENCY = 2
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    fetch_start,
    input  addr_t   fetch_addr,
    output logic    fetch_busy,
    output logic    fetch_done,
    output data_t   fetch_inst,
    output logic    fetch_err,

    input  logic    ls_start,
    input  lsu_op_e ls_op,
    input  addr_t   ls_addr,
    input  data_t   ls_wdata,
    input  strb_t   ls_wstrb,
    output logic    ls_busy,
    output logic    ls_done,
    output data_t   ls_rdata,
    output logic    ls_err
);

    axi_req_t ifu_req;
    axi_rsp_t ifu_rsp;
    axi_req_t lsu_req;
    axi_rsp_t lsu_rsp;
    axi_req_t mem_req;
    axi_rsp_t mem_rsp;

    ifu_master i_ifu (
        .clk   (clk),
        .rst   (rst),
        .start (fetch_start),
        .addr  (fetch_addr),
        .busy  (fetch_busy),
        .done  (fetch_done),
        .inst  (fetch_inst),
        .err   (fetch_err),
        .req   (ifu_req),
        .rsp   (ifu_rsp)
    );

    lsu_master i_lsu (
        .clk   (clk),
        .rst   (rst),
        .start (ls_start),
        .op    (ls_op),
        .addr  (ls_addr),
        .wdata (ls_wdata),
        .wstrb (ls_wstrb),
        .busy  (ls_busy),
        .done  (ls_done),
        .rdata (ls_rdata),
        .err   (ls_err),
        .req   (lsu_req),
        .rsp   (lsu_rsp)
    );

    // fetch sits on m0 and wins ties
    axi_arbiter i_arbiter (
        .clk    (clk),
        .rst    (rst),
        .m0_req (ifu_req),
        .m0_rsp (ifu_rsp),
        .m1_req (lsu_req),
        .m1_rsp (lsu_rsp),
        .s_req  (mem_req),
        .s_rsp  (mem_rsp)
    );

    axi_sram #(
        .MEM_WORDS    (MEM_WORDS),
        .RESP_LATENCY (RESP_LATENCY)
    ) i_sram (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

//--- rtl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram import mem_sys_pkg::*; #(
    parameter int MEM_WORDS    = 256,
    parameter int RESP_LATENCY = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t req,
    output axi_rsp_t rsp
);

    localparam int    IDX_W    = MEM_WORDS > 1 ? $clog2(MEM_WORDS) : 1;
    localparam int    CNT_W    = $clog2(RESP_LATENCY + 1);
    localparam addr_t ADDR_END = addr_t'(MEM_WORDS * 4);

    typedef enum logic {
        SRAM_IDLE,
        SRAM_BUSY
    } sram_state_e;

    data_t            mem [MEM_WORDS];
    sram_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic             is_write;
    data_t            rdata_q;
    axi_resp_e        resp_q;
    logic             rd_acc;
    logic             wr_acc;
    addr_t            acc_addr;
    logic [IDX_W-1:0] acc_idx;
    logic             in_range;
    logic             resp_due;
    logic             resp_xfer;

    // reads win if both show up, a write needs aw and w together
    assign rd_acc    = state == SRAM_IDLE && req.ar_valid;
    assign wr_acc    = state == SRAM_IDLE && !req.ar_valid && req.aw_valid && req.w_valid;
    assign acc_addr  = rd_acc ? req.ar_addr : req.aw_addr;
    assign acc_idx   = acc_addr[IDX_W+1:2]; // low two bits dropped
    assign in_range  = acc_addr < ADDR_END;
    assign resp_due  = state == SRAM_BUSY && cnt == '0;
    assign resp_xfer = resp_due && (is_write ? req.b_ready : req.r_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SRAM_IDLE;
            cnt      <= '0;
            is_write <= 1'b0;
        end else if (state == SRAM_IDLE) begin
            if (rd_acc || wr_acc) begin
                state    <= SRAM_BUSY;
                cnt      <= CNT_W'(RESP_LATENCY - 1);
                is_write <= wr_acc;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (resp_xfer) begin
            state <= SRAM_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) rdata_q <= in_range ? mem[acc_idx] : '0;
        if (rd_acc || wr_acc) resp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
    end

    always_ff @(posedge clk) begin
        if (wr_acc && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.w_strb[b]) mem[acc_idx][8*b +: 8] <= req.w_data[8*b +: 8];
            end
        end
    end

    always_comb begin
        rsp          = '0;
        rsp.ar_ready = rd_acc;
        rsp.aw_ready = wr_acc;
        rsp.w_ready  = wr_acc;
        rsp.r_data   = rdata_q;
        rsp.r_resp   = resp_q;
        rsp.r_valid  = resp_due && !is_write;
        rsp.b_resp   = resp_q;
        rsp.b_valid  = resp_due && is_write;
    end

endmodule

//--- rtl/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter import mem_sys_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t m0_req, // fetch
    output axi_rsp_t m0_rsp,
    input  axi_req_t m1_req, // load/store
    output axi_rsp_t m1_rsp,
    output axi_req_t s_req,
    input  axi_rsp_t s_rsp
);

    arb_state_e m0_state;
    arb_state_e m1_state;
    logic       sel;      // low selects fetch
    logic       m0_pend;
    logic       m1_pend;
    logic       addr_xfer;
    logic       sel_lock;

    function automatic logic has_request(axi_req_t q);
        return q.ar_valid || q.aw_valid || q.w_valid;
    endfunction

    // both masters follow the same FREE/WAIT/BUSY tracking
    function automatic arb_state_e arb_next(arb_state_e cur, axi_req_t q, axi_rsp_t p);
        arb_state_e nxt;
        nxt = cur;
        if ((q.ar_valid && p.ar_ready) ||
            (q.aw_valid && p.aw_ready && q.w_valid && p.w_ready)) begin
            nxt = ARB_BUSY;
        end else if (has_request(q)) begin
            nxt = ARB_WAIT;
        end else if ((q.r_ready && p.r_valid) || (q.b_ready && p.b_valid)) begin
            nxt = ARB_FREE;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            m0_state <= ARB_FREE;
            m1_state <= ARB_FREE;
        end else begin
            m0_state <= arb_next(m0_state, m0_req, m0_rsp);
            m1_state <= arb_next(m1_state, m1_req, m1_rsp);
        end
    end

    assign m0_pend = has_request(m0_req);
    assign m1_pend = has_request(m1_req);

    // the owner only turns BUSY on the edge after its address handshake,
    // so that cycle has to hold the select as well
    assign addr_xfer = (s_req.ar_valid && s_rsp.ar_ready) ||
                       (s_req.aw_valid && s_rsp.aw_ready);
    assign sel_lock  = m0_state == ARB_BUSY || m1_state == ARB_BUSY || addr_xfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (!sel_lock) begin
            if (m0_pend) begin
                sel <= 1'b0;
            end else if (m1_pend) begin
                sel <= 1'b1;
            end
        end
    end

    // whole channel bundles follow the select, the idle master sees zeros
    always_comb begin
        m0_rsp = '0;
        m1_rsp = '0;
        if (sel) begin
            s_req  = m1_req;
            m1_rsp = s_rsp;
        end else begin
            s_req  = m0_req;
            m0_rsp = s_rsp;
        end
    end

endmodule

//--- rtl/lsu_master.sv
`timescale 1ns/1ps

module lsu_master import mem_sys_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  lsu_op_e  op,
    input  addr_t    addr,
    input  data_t    wdata,
    input  strb_t    wstrb,
    output logic     busy,
    output logic     done,
    output data_t    rdata,
    output logic     err,
    output axi_req_t req,
    input  axi_rsp_t rsp
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_ADDR,
        LSU_RESP
    } lsu_state_e;

    lsu_state_e state;
    lsu_op_e    op_q;
    addr_t      addr_q;
    data_t      wdata_q;
    strb_t      wstrb_q;
    logic       aw_done;
    logic       w_done;
    logic       accept;
    logic       ar_xfer;
    logic       aw_xfer;
    logic       w_xfer;
    logic       resp_xfer;

    assign accept    = start && state == LSU_IDLE && !done;
    assign ar_xfer   = req.ar_valid && rsp.ar_ready;
    assign aw_xfer   = req.aw_valid && rsp.aw_ready;
    assign w_xfer    = req.w_valid && rsp.w_ready;
    assign resp_xfer = (req.r_ready && rsp.r_valid) || (req.b_ready && rsp.b_valid);
    assign busy      = start || done || state != LSU_IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= LSU_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
        end else begin
            done <= resp_xfer;
            case (state)
                LSU_IDLE: begin
                    if (accept) begin
                        state   <= LSU_ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                LSU_ADDR: begin
                    if (aw_xfer) aw_done <= 1'b1;
                    if (w_xfer) w_done <= 1'b1;
                    // a store moves on once both halves have been handed over
                    if (op_q == OP_LOAD ? ar_xfer
                                        : (aw_done || aw_xfer) && (w_done || w_xfer)) begin
                        state <= LSU_RESP;
                    end
                end
                LSU_RESP: begin
                    if (resp_xfer) begin
                        state <= LSU_IDLE;
                        err   <= (op_q == OP_LOAD ? rsp.r_resp : rsp.b_resp) == RESP_SLVERR;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (resp_xfer) rdata <= op_q == OP_LOAD ? rsp.r_data : '0;
    end

    always_comb begin
        req          = '0;
        req.ar_addr  = addr_q;
        req.ar_valid = state == LSU_ADDR && op_q == OP_LOAD;
        req.r_ready  = state == LSU_RESP && op_q == OP_LOAD;
        req.aw_addr  = addr_q;
        req.aw_valid = state == LSU_ADDR && op_q == OP_STORE && !aw_done;
        req.w_data   = wdata_q;
        req.w_strb   = wstrb_q;
        req.w_valid  = state == LSU_ADDR && op_q == OP_STORE && !w_done;
        req.b_ready  = state == LSU_RESP && op_q == OP_STORE;
    end

endmodule

//--- rtl/ifu_master.sv
`timescale 1ns/1ps

module ifu_master import mem_sys_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  addr_t    addr,
    output logic     busy,
    output logic     done,
    output data_t    inst,
    output logic     err,
    output axi_req_t req,
    input  axi_rsp_t rsp
);

    typedef enum logic [1:0] {
        IFU_IDLE,
        IFU_ADDR,
        IFU_RESP
    } ifu_state_e;

    ifu_state_e state;
    addr_t      addr_q;
    logic       accept;
    logic       r_xfer;

    // a strobe landing on the done cycle is dropped like any other busy cycle
    assign accept = start && state == IFU_IDLE && !done;
    assign r_xfer = req.r_ready && rsp.r_valid;
    assign busy   = start || done || state != IFU_IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IFU_IDLE;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= r_xfer;
            case (state)
                IFU_IDLE: if (accept) state <= IFU_ADDR;
                IFU_ADDR: if (rsp.ar_ready) state <= IFU_RESP; // ar_valid is high here
                IFU_RESP: begin
                    if (r_xfer) begin
                        state <= IFU_IDLE;
                        err   <= rsp.r_resp == RESP_SLVERR;
                    end
                end
                default: state <= IFU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= addr;
        if (r_xfer) inst <= rsp.r_data;
    end

    always_comb begin
        req          = '0; // fetch never writes
        req.ar_addr  = addr_q;
        req.ar_valid = state == IFU_ADDR;
        req.r_ready  = state == IFU_RESP;
    end

endmodule

//--- rtl/mem_sys_pkg.sv
package mem_sys_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } lsu_op_e;

    // per-master view of a transaction as seen by the arbiter
    typedef enum logic [1:0] {
        ARB_FREE = 2'b00,
        ARB_WAIT = 2'b01,
        ARB_BUSY = 2'b10
    } arb_state_e;

    typedef struct packed {
        addr_t ar_addr;
        logic  ar_valid;
        logic  r_ready;
        addr_t aw_addr;
        logic  aw_valid;
        data_t w_data;
        strb_t w_strb;
        logic  w_valid;
        logic  b_ready;
    } axi_req_t;

    typedef struct packed {
        logic      ar_ready;
        data_t     r_data;
        axi_resp_e r_resp;
        logic      r_valid;
        logic      aw_ready;
        logic      w_ready;
        axi_resp_e b_resp;
        logic      b_valid;
    } axi_rsp_t;

endpackage
